// File: cart_mapper.f
design/mapper_pkg.sv
design/mapper_cfg_if.sv
design/bank_regs.sv
design/addr_map.sv
design/flash_emu.sv
design/cart_mapper.sv
test/cart_mapper_tb.sv

// File: Bender.yml
package:
  name: cart_mapper

sources:
  - design/mapper_pkg.sv
  - design/mapper_cfg_if.sv
  - design/bank_regs.sv
  - design/addr_map.sv
  - design/flash_emu.sv
  - design/cart_mapper.sv
  - target: test
    files:
      - test/cart_mapper_tb.sv

// File: test/cart_mapper_tb.sv
`timescale 1ns/1ps
`default_nettype none

module cart_mapper_tb;
    import mapper_pkg::*;

    localparam int PERIOD = 40;
    // per-test cycle budgets that size the watchdog
    localparam int RESET_CYCLES = 4;
    localparam int BUDGET_RESET = 20;
    localparam int BUDGET_GATE = 40;
    localparam int BUDGET_ROM = 50;
    localparam int BUDGET_RAM = 40;
    localparam int BUDGET_FLASH = 60;
    localparam int TOTAL_CYCLES = RESET_CYCLES + BUDGET_RESET + BUDGET_GATE + BUDGET_ROM
                                  + BUDGET_RAM + BUDGET_FLASH;
    localparam int WATCHDOG_NS = TOTAL_CYCLES * PERIOD + 2000;

    logic SClk, rst, io_wr, io_ack;
    reg_addr_t io_addr;
    reg_data_t wr_data, io_rd_data, emu_rd_data;
    addr_hi_t mem_hi;
    logic mem_a0, mem_active, mem_read, mem_wr;
    addr_ext_t addr_ext;
    logic psram1_sel, psram2_sel, sram_sel, lb_off, ub_off, emu_catch;

    int checks;
    int errors;
    int test_start_errors;
    logic [15:0] lfsr_state;

    cart_mapper #(
        .ROM_PSRAM_BANKS(128)
    ) u_cart_mapper (
        .SClk(SClk),
        .rst(rst),
        .io_wr(io_wr),
        .io_addr(io_addr),
        .wr_data(wr_data),
        .io_rd_data(io_rd_data),
        .io_ack(io_ack),
        .mem_hi(mem_hi),
        .mem_a0(mem_a0),
        .mem_active(mem_active),
        .mem_read(mem_read),
        .mem_wr(mem_wr),
        .addr_ext(addr_ext),
        .psram1_sel(psram1_sel),
        .psram2_sel(psram2_sel),
        .sram_sel(sram_sel),
        .lb_off(lb_off),
        .ub_off(ub_off),
        .emu_catch(emu_catch),
        .emu_rd_data(emu_rd_data)
    );

    always #(PERIOD / 2) SClk = ~SClk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic random_bits(input int n, output logic [15:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[14:0], lfsr_state[0]};
        end
    endtask

    task automatic check_data(input string name, input reg_data_t got, input reg_data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input addr_ext_t got, input addr_ext_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
        end
    endtask

    task automatic finish_test(input string name);
        $display("%s: %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
    endtask

    task automatic io_write(input reg_addr_t a, input reg_data_t d);
        @(negedge SClk);
        io_addr = a;
        wr_data = d;
        io_wr = 1'b1;
        @(negedge SClk);
        io_wr = 1'b0;
    endtask

    task automatic io_read(input reg_addr_t a, input reg_data_t exp, input logic exp_ack);
        @(negedge SClk);
        io_addr = a;
        #(PERIOD / 4);
        check_data("io_rd_data", io_rd_data, exp);
        check_bit("io_ack", io_ack, exp_ack);
    endtask

    // outputs are sampled in the middle of the low phase
    task automatic mem_level(input addr_hi_t hi, input logic a0, input logic rd);
        @(negedge SClk);
        mem_hi = hi;
        mem_a0 = a0;
        mem_read = rd;
        mem_active = 1'b1;
        #(PERIOD / 4);
    endtask

    task automatic mem_idle();
        @(negedge SClk);
        mem_active = 1'b0;
        mem_read = 1'b0;
    endtask

    task automatic flash_write(input reg_data_t d, input logic exp_pass);
        @(negedge SClk);
        mem_hi = 4'h1;
        mem_read = 1'b0;
        mem_active = 1'b1;
        wr_data = d;
        mem_wr = 1'b1;
        #(PERIOD / 4);
        check_bit("psram1_sel", psram1_sel, exp_pass);
        @(negedge SClk);
        mem_wr = 1'b0;
        mem_active = 1'b0;
    endtask

    task automatic test_reset_readback();
        io_read(ROM_BANK_0, 8'hFF, 1'b1);
        io_read(ROM_BANK_0_H, 8'h03, 1'b1);
        io_read(BANK_MASK_LO, 8'hFF, 1'b1);
        io_read(BANK_MASK_HI, 8'hFF, 1'b1);
        io_read(POW_CNT, 8'h5C, 1'b1);
        io_read(8'h10, 8'h00, 1'b0);
        check_bit("sram_sel", sram_sel, 1'b0);
        check_bit("psram1_sel", psram1_sel, 1'b0);
        check_bit("psram2_sel", psram2_sel, 1'b0);
        check_bit("emu_catch", emu_catch, 1'b0);
        finish_test("reset_readback");
    endtask

    task automatic test_gating();
        io_write(POW_CNT, 8'h00);
        io_write(ROM_BANK_0_L, 8'h12);
        io_read(ROM_BANK_0_L, 8'hFF, 1'b1);
        io_write(BANK_MASK_LO, 8'h00);
        io_read(BANK_MASK_LO, 8'hFF, 1'b1);
        io_write(ROM_BANK_0, 8'h34);
        io_read(ROM_BANK_0, 8'h34, 1'b1);
        // only the unlock value gets past the locked extension
        io_write(POW_CNT, 8'h5C);
        io_read(POW_CNT, 8'h00, 1'b1);
        io_write(POW_CNT, 8'hFD);
        io_read(POW_CNT, 8'h5C, 1'b1);
        finish_test("gating");
    endtask

    task automatic test_rom_mapping();
        logic [15:0] b0, b1, m;
        random_bits(8, b0);
        random_bits(8, b1);
        random_bits(8, m);
        io_write(ROM_BANK_0_H, 8'h00);
        io_write(ROM_BANK_1_H, 8'h00);
        io_write(BANK_MASK_HI, 8'hF0);
        io_write(ROM_BANK_0, b0[7:0]);
        io_write(ROM_BANK_1, b1[7:0]);
        mem_level(4'h2, 1'b0, 1'b1);
        check_addr("addr_ext", addr_ext, b0[6:0]);
        check_bit("psram1_sel", psram1_sel, ~b0[7]);
        check_bit("psram2_sel", psram2_sel, b0[7]);
        check_bit("lb_off", lb_off, 1'b0);
        check_bit("ub_off", ub_off, 1'b0);
        mem_level(4'h3, 1'b0, 1'b1);
        check_addr("addr_ext", addr_ext, b1[6:0]);
        check_bit("psram1_sel", psram1_sel, ~b1[7]);
        check_bit("psram2_sel", psram2_sel, b1[7]);
        mem_idle();
        // apply the mask to both ROM windows
        io_write(BANK_MASK_LO, m[7:0]);
        io_write(BANK_MASK_HI, 8'hF6);
        mem_level(4'h2, 1'b0, 1'b1);
        check_addr("addr_ext", addr_ext, b0[6:0] & m[6:0]);
        check_bit("psram1_sel", psram1_sel, ~(b0[7] & m[7]));
        check_bit("psram2_sel", psram2_sel, b0[7] & m[7]);
        mem_level(4'h3, 1'b0, 1'b1);
        check_addr("addr_ext", addr_ext, b1[6:0] & m[6:0]);
        check_bit("psram1_sel", psram1_sel, ~(b1[7] & m[7]));
        check_bit("psram2_sel", psram2_sel, b1[7] & m[7]);
        mem_idle();
        io_write(LINEAR_ADDR_OFF, 8'h03);
        mem_level(4'h8, 1'b0, 1'b1);
        check_addr("addr_ext", addr_ext, 7'h38);
        check_bit("psram1_sel", psram1_sel, 1'b1);
        check_bit("psram2_sel", psram2_sel, 1'b0);
        mem_idle();
        finish_test("rom_mapping");
    endtask

    task automatic test_ram_mapping();
        logic [15:0] r;
        random_bits(3, r);
        io_write(RAM_BANK_H, 8'h00);
        io_write(RAM_BANK, {5'h00, r[2:0]});
        mem_level(4'h1, 1'b0, 1'b1);
        check_bit("sram_sel", sram_sel, 1'b1);
        check_addr("addr_ext", addr_ext, {4'h0, r[2:0]});
        check_bit("psram1_sel", psram1_sel, 1'b0);
        check_bit("lb_off", lb_off, 1'b0);
        check_bit("ub_off", ub_off, 1'b1);
        io_write(POW_CNT, 8'h1C);
        mem_level(4'h1, 1'b1, 1'b1);
        check_bit("sram_sel", sram_sel, 1'b0);
        check_bit("lb_off", lb_off, 1'b1);
        check_bit("ub_off", ub_off, 1'b0);
        // self flash moves the RAM window into ROM space
        io_write(MEMORY_CTRL, 8'h01);
        mem_level(4'h1, 1'b0, 1'b1);
        check_bit("psram1_sel", psram1_sel, 1'b1);
        check_bit("sram_sel", sram_sel, 1'b0);
        check_addr("addr_ext", addr_ext, {4'h0, r[2:0]});
        mem_idle();
        finish_test("ram_mapping");
    endtask

    task automatic test_flash_emulation();
        io_write(EMU_CNT, 8'h04);
        io_write(MEMORY_CTRL, 8'h01);
        flash_write(8'h00, 1'b0);
        flash_write(CMD_AA, 1'b0);
        flash_write(CMD_55, 1'b0);
        flash_write(CMD_WRITE, 1'b0);
        flash_write(8'h12, 1'b1);
        flash_write(8'h34, 1'b0);
        flash_write(CMD_AA, 1'b0);
        flash_write(CMD_55, 1'b0);
        flash_write(CMD_ERASE_SECTOR, 1'b0);
        mem_level(4'h1, 1'b0, 1'b1);
        check_bit("emu_catch", emu_catch, 1'b1);
        check_data("emu_rd_data", emu_rd_data, 8'hFF);
        check_bit("psram1_sel", psram1_sel, 1'b0);
        mem_idle();
        flash_write(CMD_AA, 1'b0);
        flash_write(CMD_55, 1'b0);
        flash_write(CMD_FAST, 1'b0);
        mem_level(4'h1, 1'b0, 1'b1);
        check_bit("emu_catch", emu_catch, 1'b1);
        check_data("emu_rd_data", emu_rd_data, 8'h00);
        mem_idle();
        flash_write(CMD_FAST_EXIT, 1'b0);
        mem_level(4'h1, 1'b0, 1'b1);
        check_bit("emu_catch", emu_catch, 1'b0);
        check_bit("psram1_sel", psram1_sel, 1'b1);
        mem_idle();
        finish_test("flash_emulation");
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the tests did not finish in time");
        $display("Checks failed");
        $finish;
    end

    initial begin
        SClk = 1'b0;
        rst = 1'b1;
        io_wr = 1'b0;
        io_addr = 8'h00;
        wr_data = 8'h00;
        mem_hi = 4'h0;
        mem_a0 = 1'b0;
        mem_active = 1'b0;
        mem_read = 1'b0;
        mem_wr = 1'b0;
        checks = 0;
        errors = 0;
        test_start_errors = 0;
        lfsr_state = 16'd18120;
        repeat (RESET_CYCLES) @(negedge SClk);
        rst = 1'b0;
        test_reset_readback();
        test_gating();
        test_rom_mapping();
        test_ram_mapping();
        test_flash_emulation();
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: design/cart_mapper.sv
`timescale 1ns/1ps
`default_nettype none

module cart_mapper #(
    parameter int unsigned ROM_PSRAM_BANKS = 128
) (
    input wire logic SClk,
    input wire logic rst,
    input wire logic io_wr,
    input wire mapper_pkg::reg_addr_t io_addr,
    input wire mapper_pkg::reg_data_t wr_data,
    output mapper_pkg::reg_data_t io_rd_data,
    output logic io_ack,
    input wire mapper_pkg::addr_hi_t mem_hi,
    input wire logic mem_a0,
    input wire logic mem_active,
    input wire logic mem_read,
    input wire logic mem_wr,
    output mapper_pkg::addr_ext_t addr_ext,
    output logic psram1_sel,
    output logic psram2_sel,
    output logic sram_sel,
    output logic lb_off,
    output logic ub_off,
    output logic emu_catch,
    output mapper_pkg::reg_data_t emu_rd_data
);

    logic psram_hit, ram_area;
    logic pass_read, pass_write;

    mapper_cfg_if u_cfg_if ();

    bank_regs u_bank_regs (
        .SClk(SClk),
        .rst(rst),
        .io_wr(io_wr),
        .io_addr(io_addr),
        .wr_data(wr_data),
        .rd_data(io_rd_data),
        .ack(io_ack),
        .cfg(u_cfg_if)
    );

    addr_map #(
        .ROM_PSRAM_BANKS(ROM_PSRAM_BANKS)
    ) u_addr_map (
        .mem_hi(mem_hi),
        .mem_a0(mem_a0),
        .mem_active(mem_active),
        .mem_read(mem_read),
        .cfg(u_cfg_if),
        .pass_read(pass_read),
        .pass_write(pass_write),
        .psram_hit(psram_hit),
        .ram_area(ram_area),
        .addr_ext(addr_ext),
        .psram1_sel(psram1_sel),
        .psram2_sel(psram2_sel),
        .sram_sel(sram_sel),
        .lb_off(lb_off),
        .ub_off(ub_off)
    );

    flash_emu u_flash_emu (
        .SClk(SClk),
        .rst(rst),
        .mem_wr(mem_wr),
        .wr_data(wr_data),
        .psram_hit(psram_hit),
        .ram_area(ram_area),
        .cfg(u_cfg_if),
        .pass_read(pass_read),
        .pass_write(pass_write),
        .catch(emu_catch),
        .catch_data(emu_rd_data)
    );

endmodule

`default_nettype wire

// File: design/flash_emu.sv
`timescale 1ns/1ps
`default_nettype none

module flash_emu (
    input wire logic SClk,
    input wire logic rst,
    input wire logic mem_wr,
    input wire mapper_pkg::reg_data_t wr_data,
    input wire logic psram_hit,
    input wire logic ram_area,
    mapper_cfg_if.emu cfg,
    output logic pass_read,
    output logic pass_write,
    output logic catch,
    output mapper_pkg::reg_data_t catch_data
);
    import mapper_pkg::*;

    flash_state_t state;
    logic emu_active;

    // command sequence is tracked even with emulation off
    always_ff @(posedge SClk) begin
        if (rst) begin
            state <= wait_aa;
        end else if (mem_wr && psram_hit) begin
            case (state)
                wait_aa: if (wr_data == CMD_AA) state <= wait_55;
                wait_55: state <= (wr_data == CMD_55) ? cmd : wait_aa;
                cmd: begin
                    case (wr_data)
                        CMD_FAST: state <= fast_mode;
                        CMD_WRITE: state <= single_write;
                        CMD_ERASE_SECTOR, CMD_ERASE_CHIP: state <= erase;
                        default: state <= wait_aa;
                    endcase
                end
                fast_mode: begin
                    if (wr_data == CMD_WRITE)
                        state <= fast_mode_write;
                    else if (wr_data == CMD_FAST_EXIT)
                        state <= wait_aa;
                end
                fast_mode_write: state <= fast_mode;
                single_write: state <= wait_aa;
                erase: state <= (wr_data == CMD_AA) ? wait_55 : wait_aa;
                default: state <= wait_aa;
            endcase
        end
    end

    assign emu_active = cfg.flash_emu_en & ram_area;

    assign pass_read = ~(emu_active && (state == erase || state == fast_mode));
    assign pass_write = ~emu_active || state == single_write || state == fast_mode_write;

    // blocked reads are answered with the erase pattern or status zero
    assign catch = ~pass_read & psram_hit;
    assign catch_data = (state == erase) ? 8'hFF : 8'h00;

endmodule

`default_nettype wire

// File: design/addr_map.sv
`timescale 1ns/1ps
`default_nettype none

module addr_map #(
    parameter int unsigned ROM_PSRAM_BANKS = 128
) (
    input wire mapper_pkg::addr_hi_t mem_hi,
    input wire logic mem_a0,
    input wire logic mem_active,
    input wire logic mem_read,
    mapper_cfg_if.mapper cfg,
    input wire logic pass_read,
    input wire logic pass_write,
    output logic psram_hit,
    output logic ram_area,
    output mapper_pkg::addr_ext_t addr_ext,
    output logic psram1_sel,
    output logic psram2_sel,
    output logic sram_sel,
    output logic lb_off,
    output logic ub_off
);
    import mapper_pkg::*;

    // bank limits widened by one bit so a 256-bank chip still fits
    localparam logic [9:0] PSRAM1_TOP = 10'(ROM_PSRAM_BANKS);
    localparam logic [9:0] PSRAM2_TOP = 10'(2 * ROM_PSRAM_BANKS);

    rom_bank_t bank_sel, masked_rom;
    ram_bank_t masked_ram;
    logic [9:0] bank_wide;
    logic sel_rom, sel_ram, apply_mask;
    logic psram1_addr, psram2_addr, sram_addr, psram_ok, eight_bit;

    always_comb begin
        bank_sel = 9'h000;
        sel_rom = 1'b0;
        sel_ram = 1'b0;
        apply_mask = 1'b0;
        case (mem_hi)
            4'h0: begin
            end
            4'h1: begin
                // RAM window goes to ROM space while self flashing
                sel_rom = cfg.self_flash;
                sel_ram = ~cfg.self_flash;
                bank_sel = cfg.ram_bank[8:0];
                apply_mask = cfg.apply_ram;
            end
            4'h2: begin
                sel_rom = 1'b1;
                bank_sel = cfg.rom0_bank[8:0];
                apply_mask = cfg.apply_rom0;
            end
            4'h3: begin
                sel_rom = 1'b1;
                bank_sel = cfg.rom1_bank[8:0];
                apply_mask = cfg.apply_rom1;
            end
            default: begin
                sel_rom = 1'b1;
                bank_sel = {cfg.linear_off[4:0], mem_hi};
            end
        endcase
    end

    assign masked_rom = apply_mask ? (bank_sel & cfg.rom_mask) : bank_sel;
    assign masked_ram = cfg.apply_ram ? (cfg.ram_bank[3:0] & cfg.ram_mask) : cfg.ram_bank[3:0];
    assign bank_wide = {1'b0, masked_rom};

    assign psram1_addr = sel_rom && (bank_wide < PSRAM1_TOP);
    assign psram2_addr = sel_rom && (bank_wide >= PSRAM1_TOP) && (bank_wide < PSRAM2_TOP);
    assign sram_addr = sel_ram && !masked_ram[3] && cfg.sram_en;

    assign ram_area = (mem_hi == 4'h1);
    assign psram_hit = mem_active & (psram1_addr | psram2_addr);

    // flash emulator can hold back either direction
    assign psram_ok = mem_active & (mem_read ? pass_read : pass_write);
    assign psram1_sel = psram_ok & psram1_addr;
    assign psram2_sel = psram_ok & psram2_addr;
    assign sram_sel = mem_active & sram_addr;

    // SRAM only looks at the low three bank bits
    assign addr_ext[2:0] = sel_ram ? masked_ram[2:0] : masked_rom[2:0];
    assign addr_ext[6:3] = masked_rom[6:3];

    assign eight_bit = ram_area | cfg.rom_8bit;
    assign lb_off = eight_bit & mem_a0;
    assign ub_off = eight_bit & ~mem_a0;

endmodule

`default_nettype wire

// File: design/bank_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bank_regs (
    input wire logic SClk,
    input wire logic rst,
    input wire logic io_wr,
    input wire mapper_pkg::reg_addr_t io_addr,
    input wire mapper_pkg::reg_data_t wr_data,
    output mapper_pkg::reg_data_t rd_data,
    output logic ack,
    mapper_cfg_if.regs cfg
);
    import mapper_pkg::*;

    bank_t ram_bank, rom0_bank, rom1_bank;
    linear_t linear_off;
    rom_bank_t rom_mask;
    ram_bank_t ram_mask;
    logic apply_rom0, apply_rom1, apply_ram;
    logic self_flash, sram_en, flash_emu_en, rom_8bit;
    // extension enables from POW_CNT
    logic ext_en, en_2001, en_2003;

    always_ff @(posedge SClk) begin
        if (rst) begin
            ram_bank <= BANK_RESET;
            rom0_bank <= BANK_RESET;
            rom1_bank <= BANK_RESET;
            linear_off <= 8'hFF;
            rom_mask <= 9'h1FF;
            ram_mask <= 4'hF;
            apply_rom0 <= 1'b1;
            apply_rom1 <= 1'b1;
            apply_ram <= 1'b1;
            self_flash <= 1'b0;
            sram_en <= 1'b1;
            flash_emu_en <= 1'b0;
            rom_8bit <= 1'b0;
            ext_en <= 1'b1;
            en_2001 <= 1'b1;
            en_2003 <= 1'b1;
        end else if (io_wr) begin
            case (io_addr)
                LINEAR_ADDR_OFF: linear_off <= wr_data;
                RAM_BANK: ram_bank[7:0] <= wr_data;
                ROM_BANK_0: rom0_bank[7:0] <= wr_data;
                ROM_BANK_1: rom1_bank[7:0] <= wr_data;
                RAM_BANK_L: if (en_2003) ram_bank[7:0] <= wr_data;
                ROM_BANK_0_L: if (en_2003) rom0_bank[7:0] <= wr_data;
                ROM_BANK_1_L: if (en_2003) rom1_bank[7:0] <= wr_data;
                RAM_BANK_H: if (en_2003) ram_bank[9:8] <= wr_data[1:0];
                ROM_BANK_0_H: if (en_2003) rom0_bank[9:8] <= wr_data[1:0];
                ROM_BANK_1_H: if (en_2003) rom1_bank[9:8] <= wr_data[1:0];
                MEMORY_CTRL: if (en_2003) self_flash <= wr_data[0];
                BANK_MASK_LO: if (ext_en) rom_mask[7:0] <= wr_data;
                BANK_MASK_HI: begin
                    if (ext_en) begin
                        rom_mask[8] <= wr_data[0];
                        apply_rom0 <= wr_data[1];
                        apply_rom1 <= wr_data[2];
                        apply_ram <= wr_data[3];
                        ram_mask <= wr_data[7:4];
                    end
                end
                POW_CNT: begin
                    // unlock value gets through even with the extension off
                    if (ext_en || wr_data == POW_UNLOCK) begin
                        ext_en <= wr_data[2];
                        en_2001 <= wr_data[3];
                        en_2003 <= wr_data[4];
                        sram_en <= wr_data[6];
                    end
                end
                EMU_CNT: begin
                    if (ext_en) begin
                        flash_emu_en <= wr_data[2];
                        rom_8bit <= wr_data[3];
                    end
                end
                default: begin
                end
            endcase
        end
    end

    // unmapped addresses read zero without ack
    always_comb begin
        ack = 1'b1;
        rd_data = 8'h00;
        case (io_addr)
            LINEAR_ADDR_OFF: rd_data = linear_off;
            RAM_BANK, RAM_BANK_L: rd_data = ram_bank[7:0];
            ROM_BANK_0, ROM_BANK_0_L: rd_data = rom0_bank[7:0];
            ROM_BANK_1, ROM_BANK_1_L: rd_data = rom1_bank[7:0];
            RAM_BANK_H: rd_data = {6'h00, ram_bank[9:8]};
            ROM_BANK_0_H: rd_data = {6'h00, rom0_bank[9:8]};
            ROM_BANK_1_H: rd_data = {6'h00, rom1_bank[9:8]};
            MEMORY_CTRL: rd_data = {7'h00, self_flash};
            BANK_MASK_LO: rd_data = rom_mask[7:0];
            BANK_MASK_HI: rd_data = {ram_mask, apply_ram, apply_rom1, apply_rom0, rom_mask[8]};
            POW_CNT: rd_data = {1'b0, sram_en, 1'b0, en_2003, en_2001, ext_en, 2'b00};
            EMU_CNT: rd_data = {4'h0, rom_8bit, flash_emu_en, 2'b00};
            default: ack = 1'b0;
        endcase
    end

    assign cfg.ram_bank = ram_bank;
    assign cfg.rom0_bank = rom0_bank;
    assign cfg.rom1_bank = rom1_bank;
    assign cfg.linear_off = linear_off;
    assign cfg.rom_mask = rom_mask;
    assign cfg.ram_mask = ram_mask;
    assign cfg.apply_rom0 = apply_rom0;
    assign cfg.apply_rom1 = apply_rom1;
    assign cfg.apply_ram = apply_ram;
    assign cfg.self_flash = self_flash;
    assign cfg.sram_en = sram_en;
    assign cfg.flash_emu_en = flash_emu_en;
    assign cfg.rom_8bit = rom_8bit;

endmodule

`default_nettype wire

// File: design/mapper_cfg_if.sv
`timescale 1ns/1ps
`default_nettype none

interface mapper_cfg_if;
    import mapper_pkg::*;

    bank_t ram_bank;
    bank_t rom0_bank;
    bank_t rom1_bank;
    linear_t linear_off;
    rom_bank_t rom_mask;
    ram_bank_t ram_mask;
    logic apply_rom0;
    logic apply_rom1;
    logic apply_ram;
    logic self_flash;
    logic sram_en;
    logic flash_emu_en;
    logic rom_8bit;

    modport regs (
        output ram_bank, rom0_bank, rom1_bank, linear_off, rom_mask, ram_mask,
        output apply_rom0, apply_rom1, apply_ram,
        output self_flash, sram_en, flash_emu_en, rom_8bit
    );

    modport mapper (
        input ram_bank, rom0_bank, rom1_bank, linear_off, rom_mask, ram_mask,
        input apply_rom0, apply_rom1, apply_ram,
        input self_flash, sram_en, flash_emu_en, rom_8bit
    );

    modport emu (input flash_emu_en);

endinterface

`default_nettype wire

// File: design/mapper_pkg.sv
`default_nettype none

package mapper_pkg;

    typedef logic [7:0] reg_addr_t;
    typedef logic [7:0] reg_data_t;
    typedef logic [9:0] bank_t;
    typedef logic [8:0] rom_bank_t;
    typedef logic [3:0] ram_bank_t;
    typedef logic [7:0] linear_t;
    typedef logic [6:0] addr_ext_t;
    typedef logic [3:0] addr_hi_t;

    typedef enum logic [2:0] {
        wait_aa,
        wait_55,
        cmd,
        fast_mode,
        fast_mode_write,
        single_write,
        erase
    } flash_state_t;

    // 2001 mapper
    localparam reg_addr_t LINEAR_ADDR_OFF = 8'hC0;
    localparam reg_addr_t RAM_BANK = 8'hC1;
    localparam reg_addr_t ROM_BANK_0 = 8'hC2;
    localparam reg_addr_t ROM_BANK_1 = 8'hC3;

    // 2003 mapper
    localparam reg_addr_t MEMORY_CTRL = 8'hCE;
    localparam reg_addr_t RAM_BANK_L = 8'hD0;
    localparam reg_addr_t RAM_BANK_H = 8'hD1;
    localparam reg_addr_t ROM_BANK_0_L = 8'hD2;
    localparam reg_addr_t ROM_BANK_0_H = 8'hD3;
    localparam reg_addr_t ROM_BANK_1_L = 8'hD4;
    localparam reg_addr_t ROM_BANK_1_H = 8'hD5;

    // nileswan extension
    localparam reg_addr_t POW_CNT = 8'hE2;
    localparam reg_addr_t BANK_MASK_LO = 8'hE4;
    localparam reg_addr_t BANK_MASK_HI = 8'hE5;
    localparam reg_addr_t EMU_CNT = 8'hE6;

    localparam reg_data_t POW_UNLOCK = 8'hFD;
    localparam bank_t BANK_RESET = 10'h3FF;

    // flash command bytes
    localparam reg_data_t CMD_AA = 8'hAA;
    localparam reg_data_t CMD_55 = 8'h55;
    localparam reg_data_t CMD_FAST = 8'h20;
    localparam reg_data_t CMD_WRITE = 8'hA0;
    localparam reg_data_t CMD_ERASE_SECTOR = 8'h30;
    localparam reg_data_t CMD_ERASE_CHIP = 8'h10;
    localparam reg_data_t CMD_FAST_EXIT = 8'h90;

endpackage

`default_nettype wire
